// File: list.f
+incdir+test
source/m68k_bus_pkg.sv
source/cpu_req_stage.sv
source/m68k_bus_bridge.sv
source/dtack_mem.sv
source/m68k_subsys_top.sv
test/tb_top.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f list.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

// File: test/tb_ref.svh
// Testbench reference model of the bus memory with a Fibonacci LFSR for stimulus
`ifndef TB_REF_SVH
`define TB_REF_SVH

    logic [DATA_W-1:0] ref_mem [256];       // Mirrors the 256 implemented words
    logic [31:0]       lfsr_q = 32'h7552;   // Stimulus generator state

    // Memory clears at reset, so does the model
    function automatic void clear_model();
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = '0;
        end
    endfunction

    // Apply one access to the model and give the expected response
    function automatic bus_rsp_t ref_access(input bus_req_t r);
        bus_rsp_t   rsp_e;
        logic [7:0] idx;
        idx         = r.addr[7:0];           // Upper address bits alias
        rsp_e.rdata = '0;                    // Writes answer zero
        if (r.we) begin
            if (r.be[1]) begin
                ref_mem[idx][15:8] = r.wdata[15:8];
            end
            if (r.be[0]) begin
                ref_mem[idx][7:0] = r.wdata[7:0];
            end
        end else begin
            rsp_e.rdata = ref_mem[idx];      // Whole word, strobes ignored
        end
        return rsp_e;
    endfunction

    // Taps 32, 22, 2, 1; one step per bit handed out
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

`endif

// File: test/tb_top.sv
// Testbench for the 68000 bus subsystem, checking responses against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_top import m68k_bus_pkg::*; ();

    localparam int     WAIT_STATES = 2;
    localparam int     MEM_AW      = 8;
    localparam int     CLK_NS      = 40;
    localparam int     N_OPS       = 71;     // Commands over all tests
    localparam int     FIXED_CYC   = 156;    // Reset, idle and stall windows
    localparam int     OP_LIMIT    = 4 * (WAIT_STATES + 12);
    localparam longint WATCHDOG_NS = 2 * (N_OPS * (WAIT_STATES + 12) + FIXED_CYC) * CLK_NS;

    logic            clk;
    logic            rst;
    logic            halt_n;
    logic            br_n;
    logic            cmd_valid;
    bus_req_t        cmd;
    logic            busy;
    logic            rsp_valid;
    bus_rsp_t        rsp;
    logic            bg_n;
    logic            as_n;
    logic [FC_W-1:0] fc;

    bus_rsp_t exp_q [$];                     // Expected responses in issue order
    string    cur_test;
    int       errors;
    int       err_mark;
    int       pass_cnt;
    int       fail_cnt;

    `include "tb_ref.svh"

    m68k_subsys_top #(
        .WAIT_STATES (WAIT_STATES),
        .MEM_AW      (MEM_AW)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .halt_n    (halt_n),
        .br_n      (br_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .bg_n      (bg_n),
        .as_n      (as_n),
        .fc        (fc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_fc(input string name, input logic [FC_W-1:0] exp,
                            input logic [FC_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h actual %h", name, exp.rdata, act.rdata);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            pass_cnt++;
            $display("PASS %s", cur_test);
        end else begin
            fail_cnt++;
            $display("FAIL %s (%0d errors)", cur_test, errors - err_mark);
        end
    endtask

    function automatic bus_req_t make_req(input logic [ADDR_W-1:0] addr, input logic we,
                                          input logic [1:0] be, input logic [DATA_W-1:0] wdata,
                                          input logic [FC_W-1:0] fcode);
        bus_req_t r;
        r.addr  = addr;
        r.we    = we;
        r.be    = be;
        r.wdata = wdata;
        r.fc    = fcode;
        return r;
    endfunction

    // One-cycle command strobe, expected value taken at issue
    task automatic send_cmd(input bus_req_t r);
        cmd       = r;
        cmd_valid = 1'b1;
        exp_q.push_back(ref_access(r));
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // Busy low and the checker has taken the response
    task automatic wait_done();
        int n;
        n = 0;
        while ((busy || exp_q.size() != 0) && n < OP_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy || exp_q.size() != 0) begin
            $display("Command in test %s never completed", cur_test);
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic wait_as_low();
        int n;
        n = 0;
        while (as_n && n < OP_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (as_n) begin
            $display("Bus cycle never started in test %s", cur_test);
            errors++;
        end
    endtask

    // Stalled window: no bus cycle, no response
    task automatic hold_check(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_bit({cur_test, " as_n"}, 1'b1, as_n);
            check_bit({cur_test, " rsp_valid"}, 1'b0, rsp_valid);
        end
    endtask

    // Response checker, sampled mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Response without a pending command in test %s", cur_test);
                    errors++;
                end else begin
                    check_rsp(cur_test, exp_q.pop_front(), rsp);
                end
            end
        end
    end

    initial begin
        bus_req_t    r;
        logic [31:0] rnd;
        int          n;
        rst       = 1'b1;
        halt_n    = 1'b1;
        br_n      = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        errors    = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        cur_test  = "reset";
        clear_model();
        repeat (16) @(negedge clk);
        rst = 1'b0;

        begin_test("reset");
        check_bit("reset as_n", 1'b1, as_n);
        check_bit("reset bg_n", 1'b1, bg_n);
        check_bit("reset busy", 1'b0, busy);
        hold_check(20);
        end_test();

        begin_test("word_rw");
        r = make_req(23'h000012, 1'b1, 2'b11, 16'hBEEF, 3'b101);
        send_cmd(r);
        wait_as_low();
        check_fc("word_rw fc write", 3'b101, fc);
        wait_done();
        r = make_req(23'h000012, 1'b0, 2'b11, 16'h0000, 3'b110);
        send_cmd(r);
        wait_as_low();
        check_fc("word_rw fc read", 3'b110, fc);
        wait_done();
        end_test();

        begin_test("byte_lanes");
        send_cmd(make_req(23'h000040, 1'b1, 2'b10, 16'hA1B2, 3'b001));   // Upper lane
        wait_done();
        send_cmd(make_req(23'h000040, 1'b1, 2'b01, 16'hC3D4, 3'b001));   // Lower lane
        wait_done();
        send_cmd(make_req(23'h000040, 1'b0, 2'b11, 16'h0000, 3'b010));
        wait_done();
        end_test();

        begin_test("random_traffic");
        for (int i = 0; i < 64; i++) begin
            rnd          = lfsr_take(15);
            r.addr[22:8] = rnd[14:0];            // Aliased upper bits
            r.addr[7:4]  = 4'h1;                 // Keep to 16 words for reuse
            rnd          = lfsr_take(4);
            r.addr[3:0]  = rnd[3:0];
            rnd          = lfsr_take(1);
            r.we         = rnd[0];
            rnd          = lfsr_take(2);
            r.be         = rnd[1:0];
            rnd          = lfsr_take(16);
            r.wdata      = rnd[15:0];
            rnd          = lfsr_take(3);
            r.fc         = rnd[2:0];
            send_cmd(r);
            wait_done();
        end
        end_test();

        begin_test("bus_grant");
        br_n = 1'b0;
        n    = 0;
        while (bg_n && n < 10) begin
            @(negedge clk);
            n++;
        end
        check_bit("bus_grant bg_n low", 1'b0, bg_n);
        repeat (2) @(negedge clk);               // cen follows grant a cycle late
        send_cmd(make_req(23'h000012, 1'b0, 2'b11, 16'h0000, 3'b101));
        hold_check(30);
        check_bit("bus_grant bg_n held", 1'b0, bg_n);
        br_n = 1'b1;
        @(negedge clk);
        check_bit("bus_grant bg_n released", 1'b1, bg_n);
        wait_done();
        end_test();

        begin_test("halt");
        halt_n = 1'b0;
        repeat (2) @(negedge clk);
        send_cmd(make_req(23'h000040, 1'b0, 2'b11, 16'h0000, 3'b110));
        hold_check(50);
        halt_n = 1'b1;
        wait_done();
        end_test();

        $display("Tests: %0d passed, %0d failed, %0d check errors", pass_cnt, fail_cnt, errors);
        if (errors == 0 && fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/m68k_subsys_top.sv
// 68000 bus subsystem top with request stage, bus bridge and wait-stated memory
`timescale 1ns/1ps
`default_nettype none

module m68k_subsys_top import m68k_bus_pkg::*; #(
    parameter int WAIT_STATES = 2,  // Memory wait states
    parameter int MEM_AW      = 8   // Memory word address bits
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            halt_n,
    input  wire logic            br_n,
    input  wire logic            cmd_valid,
    input  wire bus_req_t        cmd,
    output      logic            busy,
    output      logic            rsp_valid,
    output      bus_rsp_t        rsp,
    output      logic            bg_n,
    output      logic            as_n,
    output      logic [FC_W-1:0] fc
);

    // Core side
    logic              cen;
    logic              data_ack;
    logic              rd_ena;
    logic              wr_ena;
    bus_req_t          req;
    logic [DATA_W-1:0] rdata;

    // 68000 bus
    logic              uds_n;
    logic              lds_n;
    logic              rw_n;
    logic [ADDR_W-1:0] eab;
    logic [DATA_W-1:0] edb_out;
    logic [DATA_W-1:0] edb_in;
    logic              dtack_n;

    cpu_req_stage u_req (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .cen       (cen),
        .data_ack  (data_ack),
        .rdata_in  (rdata),
        .rd_ena    (rd_ena),
        .wr_ena    (wr_ena),
        .req       (req)
    );

    m68k_bus_bridge u_bridge (
        .clk      (clk),
        .rst      (rst),
        .halt_n   (halt_n),
        .br_n     (br_n),
        .bg_n     (bg_n),
        .rd_ena   (rd_ena),
        .wr_ena   (wr_ena),
        .req      (req),
        .cen      (cen),
        .data_ack (data_ack),
        .rdata    (rdata),
        .as_n     (as_n),
        .uds_n    (uds_n),
        .lds_n    (lds_n),
        .rw_n     (rw_n),
        .eab      (eab),
        .edb_out  (edb_out),
        .fc       (fc),
        .dtack_n  (dtack_n),
        .edb_in   (edb_in)
    );

    dtack_mem #(
        .WAIT_STATES (WAIT_STATES),
        .MEM_AW      (MEM_AW)
    ) u_mem (
        .clk     (clk),
        .rst     (rst),
        .as_n    (as_n),
        .uds_n   (uds_n),
        .lds_n   (lds_n),
        .rw_n    (rw_n),
        .eab     (eab),
        .edb_out (edb_out),
        .dtack_n (dtack_n),
        .edb_in  (edb_in)
    );

endmodule

`default_nettype wire

// File: source/dtack_mem.sv
// Word memory on the 68000 bus with byte-lane writes and wait-stated DTACK
`timescale 1ns/1ps
`default_nettype none

module dtack_mem import m68k_bus_pkg::*; #(
    parameter int WAIT_STATES = 2,  // Extra cycles before DTACK
    parameter int MEM_AW      = 8   // Implemented word address bits
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              as_n,
    input  wire logic              uds_n,
    input  wire logic              lds_n,
    input  wire logic              rw_n,
    input  wire logic [ADDR_W-1:0] eab,
    input  wire logic [DATA_W-1:0] edb_out,
    output      logic              dtack_n,
    output      logic [DATA_W-1:0] edb_in
);

    localparam int DEPTH = 1 << MEM_AW;
    localparam int CNT_W = $clog2(WAIT_STATES + 2);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [CNT_W-1:0]  wait_cnt;
    logic [MEM_AW-1:0] idx;
    logic              hit;

    // Upper address bits alias
    assign idx = eab[MEM_AW-1:0];
    // Last wait cycle of a pending access
    assign hit = !as_n && dtack_n && (wait_cnt == CNT_W'(WAIT_STATES));

    // Wait-state counter and DTACK
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
            dtack_n  <= 1'b1;
        end else if (as_n) begin
            wait_cnt <= '0;
            dtack_n  <= 1'b1;           // Released once AS is gone
        end else if (hit) begin
            dtack_n  <= 1'b0;
        end else if (dtack_n) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Storage with per-lane writes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (hit && !rw_n) begin
            if (!uds_n) begin
                mem[idx][15:8] <= edb_out[15:8];
            end
            if (!lds_n) begin
                mem[idx][7:0] <= edb_out[7:0];
            end
        end
    end

    // Read data, held while DTACK is low
    always_ff @(posedge clk) begin
        if (hit && rw_n) begin
            edb_in <= mem[idx];
        end
    end

    // DTACK only trails AS by the one release cycle
    a_dtack_with_as: assert property (@(posedge clk) disable iff (rst)
        (as_n && !dtack_n) |-> $rose(as_n))
        else $error("dtack_mem: DTACK low without address strobe");

endmodule

`default_nettype wire

// File: source/m68k_bus_bridge.sv
// Bus bridge from core strobes to the asynchronous 68000 bus with cen and grant logic
`timescale 1ns/1ps
`default_nettype none

module m68k_bus_bridge import m68k_bus_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    // 68000 control inputs
    input  wire logic              halt_n,
    input  wire logic              br_n,        // Bus request from other master
    output      logic              bg_n,        // Bus grant
    // Core side
    input  wire logic              rd_ena,
    input  wire logic              wr_ena,
    input  wire bus_req_t          req,
    output      logic              cen,         // Core clock enable
    output      logic              data_ack,
    output      logic [DATA_W-1:0] rdata,
    // 68000 bus
    output      logic              as_n,
    output      logic              uds_n,
    output      logic              lds_n,
    output      logic              rw_n,
    output      logic [ADDR_W-1:0] eab,         // A23..A1
    output      logic [DATA_W-1:0] edb_out,
    output      logic [FC_W-1:0]   fc,
    input  wire logic              dtack_n,
    input  wire logic [DATA_W-1:0] edb_in
);

    logic strobe;
    logic bus_free;

    assign strobe   = rd_ena | wr_ena;
    // Bus can be handed over only between cycles
    assign bus_free = as_n && !strobe;

    assign data_ack = ~dtack_n;
    assign rdata    = edb_in;

    // Address side follows the held request
    assign eab     = req.addr;
    assign edb_out = req.wdata;
    assign fc      = req.fc;

    // Data strobes qualified by AS
    assign uds_n = ~(req.be[BE_UPPER] & ~as_n);
    assign lds_n = ~(req.be[BE_LOWER] & ~as_n);
    // Read unless a write cycle is running
    assign rw_n  = as_n | ~req.we;

    // Address strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            as_n <= 1'b1;
        end else if (strobe) begin
            as_n <= 1'b0;               // Start of bus cycle
        end else if (data_ack) begin
            as_n <= 1'b1;               // Memory answered
        end
    end

    // Clock enable: full rate between cycles, half rate during one
    always_ff @(posedge clk) begin
        if (rst) begin
            cen <= 1'b1;
        end else begin
            cen <= (~cen | as_n) & halt_n & bg_n;
        end
    end

    // Bus arbitration
    always_ff @(posedge clk) begin
        if (rst) begin
            bg_n <= 1'b1;
        end else if (br_n) begin
            bg_n <= 1'b1;               // Release follows request
        end else if (bus_free) begin
            bg_n <= 1'b0;
        end
    end

    // Grant never starts in the middle of a bus cycle
    a_grant_idle: assert property (@(posedge clk) disable iff (rst)
        $fell(bg_n) |-> as_n)
        else $error("m68k_bus_bridge: bus granted during a cycle");

endmodule

`default_nettype wire

// File: source/cpu_req_stage.sv
// Core-side request stage turning one held command into paced read/write strobes
`timescale 1ns/1ps
`default_nettype none

module cpu_req_stage import m68k_bus_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    // Command side
    input  wire logic              cmd_valid,   // One-cycle command strobe
    input  wire bus_req_t          cmd,
    output      logic              busy,
    output      logic              rsp_valid,   // One-cycle response pulse
    output      bus_rsp_t          rsp,
    // Bridge side
    input  wire logic              cen,         // Core clock enable
    input  wire logic              data_ack,    // Inverted DTACK
    input  wire logic [DATA_W-1:0] rdata_in,
    output      logic              rd_ena,
    output      logic              wr_ena,
    output      bus_req_t          req          // Held for the whole access
);

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for a command
        ST_ISSUE,   // Command latched and waiting for cen
        ST_WAIT     // Strobe sent and waiting for acknowledge
    } state_t;

    state_t state_q;
    logic   accept;
    logic   strobe;
    logic   ack_seen;

    // Commands are taken only when nothing is pending
    assign accept   = cmd_valid && (state_q == ST_IDLE);
    // Strobe leaves on the first enabled cycle after latching
    assign strobe   = (state_q == ST_ISSUE) && cen;
    // Acknowledge counts only on an enabled core cycle
    assign ack_seen = (state_q == ST_WAIT) && cen && data_ack;

    assign rd_ena = strobe && !req.we;
    assign wr_ena = strobe && req.we;

    // Busy tracks the FSM and falls with rsp_valid
    assign busy = (state_q != ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (strobe) begin
                        state_q <= ST_WAIT;     // One strobe per access
                    end
                end
                ST_WAIT: begin
                    if (ack_seen) begin
                        state_q   <= ST_IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command payload loaded on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            req <= cmd;
        end
    end

    // Response payload with zero for writes
    always_ff @(posedge clk) begin
        if (ack_seen) begin
            rsp.rdata <= req.we ? '0 : rdata_in;
        end
    end

    // Strobes are single pulses and never overlap
    a_strobe_pulse: assert property (@(posedge clk) disable iff (rst)
        (rd_ena || wr_ena) |-> !(rd_ena && wr_ena) ##1 !(rd_ena || wr_ena))
        else $error("cpu_req_stage: strobe overlap or longer than one cycle");

    // A strobe is only ever seen on an enabled core cycle
    a_strobe_cen: assert property (@(posedge clk) disable iff (rst)
        (rd_ena || wr_ena) |-> cen)
        else $error("cpu_req_stage: strobe without cen");

endmodule

`default_nettype wire

// File: source/m68k_bus_pkg.sv
// 68000 bus subsystem package with shared widths and request/response structs
`default_nettype none

package m68k_bus_pkg;

    // Word address, maps onto A23..A1
    localparam int ADDR_W = 23;
    // Data bus width
    localparam int DATA_W = 16;

    // Function code width on FC2..FC0
    localparam int FC_W = 3;

    // One bus access as issued by the core side
    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // Word address
        logic              we;      // High for writes
        logic [1:0]        be;      // Byte enables, upper then lower
        logic [DATA_W-1:0] wdata;   // Write data
        logic [FC_W-1:0]   fc;      // Function code, driven out only
    } bus_req_t;

    // Result of one access, zero for writes
    typedef struct packed {
        logic [DATA_W-1:0] rdata;   // Read data
    } bus_rsp_t;

    // Byte lane positions inside be
    localparam int BE_UPPER = 1;    // UDS lane, D15..D8
    localparam int BE_LOWER = 0;    // LDS lane, D7..D0

endpackage

`default_nettype wire
